/* test/precise_state_patterns.txt */
# test op a b c rd | expected: rd_value issue_tag recovering store_perm full empty
# iss/sto: a=reg  ex/mem: a=tag b=reg c=value  st/exc: a=tag  (all but test in hex)
1 nop 0 0 0   00 0   0 0 0 0 1
1 nop 0 0 0   05 0   0 0 0 0 1
1 nop 0 0 0   1f 0   0 0 0 0 1
2 iss 1 0 0   01 0   1 0 0 0 0
2 iss 2 0 0   02 0   2 0 0 0 0
2 iss 3 0 0   03 0   3 0 0 0 0
2 ex  2 3 33  03 33  3 0 0 0 0
2 mem 1 2 22  02 22  3 0 0 0 0
2 ex  0 1 11  01 11  3 0 0 0 1
3 iss 4 0 0   04 0   4 0 0 0 0
3 iss 5 0 0   05 0   5 0 0 0 0
3 iss 6 0 0   06 0   6 0 0 0 0
3 iss 7 0 0   07 0   7 0 0 0 0
3 iss 8 0 0   08 0   0 0 0 0 0
3 iss 9 0 0   09 0   1 0 0 0 0
3 iss a 0 0   0a 0   2 0 0 1 0
3 iss b 0 0   0b 0   2 0 0 1 0
3 ex  3 4 44  04 44  2 0 0 0 0
3 ex  4 5 55  05 55  2 0 0 0 0
3 ex  5 6 66  06 66  2 0 0 0 0
3 ex  6 7 77  07 77  2 0 0 0 0
3 ex  7 8 88  08 88  2 0 0 0 0
3 ex  0 9 99  09 99  2 0 0 0 0
3 ex  1 a aa  0a aa  2 0 0 0 1
4 sto 0 0 0   00 0   3 0 1 0 0
4 nop 0 0 0   00 0   3 0 1 0 0
4 st  2 0 0   00 0   3 0 0 0 1
5 iss 1 0 0   01 11  4 0 0 0 0
5 iss 2 0 0   02 22  5 0 0 0 0
5 iss 3 0 0   03 33  6 0 0 0 0
5 mem 4 2 222 02 222 6 0 0 0 0
5 ex  5 3 333 03 333 6 0 0 0 0
5 exc 3 0 0   01 11  6 0 0 0 0
5 nop 0 0 0   01 11  6 1 0 0 0
5 iss 9 0 0   03 33  5 1 0 0 0
5 nop 0 0 0   02 22  4 1 0 0 0
5 nop 0 0 0   01 11  3 0 0 0 1
5 nop 0 0 0   09 99  3 0 0 0 1

/* precise_state.f */
+incdir+hdl
hdl/hist_pkg.sv
hdl/rollback_if.sv
hdl/register_file.sv
hdl/history_file.sv
hdl/precise_state_top.sv
test/precise_state_props.sv
test/precise_state_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module precise_state_tb \
    -f precise_state.f -o sim_precise_state

./obj_dir/sim_precise_state | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
exit 1

/* test/precise_state_tb.sv */
`timescale 1ns/10ps

module precise_state_tb;

    localparam int OP_NOP = 0;
    localparam int OP_ISS = 1;
    localparam int OP_STO = 2;
    localparam int OP_EX  = 3;
    localparam int OP_MEM = 4;
    localparam int OP_ST  = 5;
    localparam int OP_EXC = 6;

    typedef struct packed {
        int          test;
        int          op;
        logic [31:0] a, b, c, rd, exp_rd, exp_tag, exp_rec, exp_st, exp_full, exp_empty;
    } pattern_t;

    logic clk_i, arst_n_i, issue_i, issue_store_i, ex_done_i, mem_done_i, st_done_i, exc_i;
    hist_pkg::reg_idx_t issue_reg_i, ex_reg_i, mem_reg_i, rd_reg_i;
    hist_pkg::hf_ptr_t  issue_tag_o, ex_tag_i, mem_tag_i, st_tag_i, exc_tag_i;
    hist_pkg::word_t    ex_value_i, mem_value_i, rd_value_o;
    logic full_o, empty_o, store_permission_o, recovering_o;

    pattern_t pats [$];
    int errors, test_errors, cycles, limit;

    // reference model state, only used to cross-check the pattern file
    logic [31:0] m_regs [32];
    logic [4:0]  m_reg  [8];
    logic [31:0] m_old  [8];
    int          m_state [8];
    logic [2:0]  m_head, m_tail;
    logic        m_rec;

    precise_state_top i_precise_state_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic load_patterns();
        int fd, n;
        string line, op;
        pattern_t p;

        fd = $fopen("test/precise_state_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h %h", p.test, op, p.a, p.b,
                        p.c, p.rd, p.exp_rd, p.exp_tag, p.exp_rec, p.exp_st, p.exp_full,
                        p.exp_empty);
            if (line.len() > 0 && line[0] != "#" && n == 12) begin
                case (op)
                    "iss":   p.op = OP_ISS;
                    "sto":   p.op = OP_STO;
                    "ex":    p.op = OP_EX;
                    "mem":   p.op = OP_MEM;
                    "st":    p.op = OP_ST;
                    "exc":   p.op = OP_EXC;
                    default: p.op = OP_NOP;
                endcase
                pats.push_back(p);
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_inputs(input pattern_t p);
        logic is_ex;
        logic is_mem;

        is_ex  = (p.op == OP_EX);
        is_mem = (p.op == OP_MEM);
        issue_i       = (p.op == OP_ISS) || (p.op == OP_STO);
        issue_store_i = (p.op == OP_STO);
        issue_reg_i   = p.a[4:0];
        ex_done_i     = is_ex;
        mem_done_i    = is_mem;
        st_done_i     = (p.op == OP_ST);
        exc_i         = (p.op == OP_EXC);
        // idle ports carry other values so that a crossed route shows up
        ex_tag_i      = is_ex ? p.a[2:0] : ~p.a[2:0];
        mem_tag_i     = is_mem ? p.a[2:0] : ~p.a[2:0];
        st_tag_i      = (p.op == OP_ST) ? p.a[2:0] : ~p.a[2:0];
        exc_tag_i     = (p.op == OP_EXC) ? p.a[2:0] : ~p.a[2:0];
        ex_reg_i      = is_ex ? p.b[4:0] : ~p.b[4:0];
        mem_reg_i     = is_mem ? p.b[4:0] : ~p.b[4:0];
        ex_value_i    = is_ex ? p.c : ~p.c;
        mem_value_i   = is_mem ? p.c : ~p.c;
        rd_reg_i      = p.rd[4:0];
    endtask

    task automatic model_step(input pattern_t p);
        logic [2:0] walk;
        logic       fault_head;

        if (m_rec) begin
            // youngest slot first, one restore per cycle
            m_tail = m_tail - 3'd1;
            if (m_reg[m_tail] != 5'd0) m_regs[m_reg[m_tail]] = m_old[m_tail];
            m_state[m_tail] = 0;
            if (m_tail == m_head) m_rec = 1'b0;
        end else begin
            fault_head = (m_state[m_head] == 4);
            if ((p.op == OP_ISS || p.op == OP_STO) && (m_tail + 3'd1) != m_head) begin
                m_reg[m_tail]   = p.a[4:0];
                m_old[m_tail]   = m_regs[p.a[4:0]];
                m_state[m_tail] = (p.op == OP_STO) ? 2 : 1;
                m_tail = m_tail + 3'd1;
            end
            if (p.op == OP_EX || p.op == OP_MEM) begin
                if (p.b[4:0] != 5'd0) m_regs[p.b[4:0]] = p.c;
            end
            if (p.op == OP_EX || p.op == OP_MEM || p.op == OP_ST) begin
                if (m_state[p.a[2:0]] != 0) m_state[p.a[2:0]] = 3;
            end
            if (p.op == OP_EXC && m_state[p.a[2:0]] != 0) m_state[p.a[2:0]] = 4;
            walk = m_head;
            while (walk != m_tail && m_state[walk] == 3) begin
                m_state[walk] = 0;
                walk = walk + 3'd1;
            end
            m_head = walk;
            if (fault_head) m_rec = 1'b1;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, act);
        if (exp !== act) begin
            $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_model(input int idx, input pattern_t p);
        if (p.exp_rd !== m_regs[p.rd[4:0]] || p.exp_tag !== 32'(m_tail)
            || p.exp_rec !== 32'(m_rec) || p.exp_st !== 32'(m_state[m_head] == 2)
            || p.exp_full !== 32'((m_tail + 3'd1) == m_head)
            || p.exp_empty !== 32'(m_head == m_tail)) begin
            $display("pattern line %0d disagrees with the reference model", idx);
            errors++;
            test_errors++;
        end
    endtask

    initial begin
        int cur_test;

        errors = 0;
        test_errors = 0;
        cycles = 0;
        limit = 0;
        arst_n_i = 1'b0;
        drive_inputs('0);
        for (int r = 0; r < 32; r++) m_regs[r] = '0;
        for (int s = 0; s < 8; s++) m_state[s] = 0;
        m_head = '0;
        m_tail = '0;
        m_rec = 1'b0;
        load_patterns();
        limit = pats.size() + 50;
        repeat (5) @(posedge clk_i);
        #2 arst_n_i = 1'b1;
        cur_test = (pats.size() > 0) ? pats[0].test : 0;
        for (int k = 0; k < pats.size(); k++) begin
            if (pats[k].test != cur_test) begin
                $display("test %0d finished with %0d errors", cur_test, test_errors);
                cur_test = pats[k].test;
                test_errors = 0;
            end
            drive_inputs(pats[k]);
            @(posedge clk_i);
            #1;
            model_step(pats[k]);
            check_model(k, pats[k]);
            check_value("rd_value_o", pats[k].exp_rd, rd_value_o);
            check_value("issue_tag_o", pats[k].exp_tag, 32'(issue_tag_o));
            check_value("recovering_o", pats[k].exp_rec, 32'(recovering_o));
            check_value("store_permission_o", pats[k].exp_st, 32'(store_permission_o));
            check_value("full_o", pats[k].exp_full, 32'(full_o));
            check_value("empty_o", pats[k].exp_empty, 32'(empty_o));
            #1;
        end
        $display("test %0d finished with %0d errors", cur_test, test_errors);
        drive_inputs('0);
        $display("%0d pattern lines, %0d errors", pats.size(), errors);
        if (errors == 0 && pats.size() > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* test/precise_state_props.sv */
`timescale 1ns/10ps

`include "hist_defines.svh"

module precise_state_props (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  ex_done_i,
    input  hist_pkg::hf_ptr_t     ex_tag_i,
    input  logic                  mem_done_i,
    input  hist_pkg::hf_ptr_t     mem_tag_i,
    input  logic                  st_done_i,
    input  hist_pkg::hf_ptr_t     st_tag_i,
    input  logic                  empty_o,
    input  logic                  recovering_o,
    input  hist_pkg::slot_state_e slot_state [`HF_DEPTH]
);

    // two pipelines never finish the same instruction
    a_ex_mem_tags: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ex_done_i && mem_done_i) |-> (ex_tag_i != mem_tag_i)) else $error("ex/mem tag clash");
    a_ex_st_tags: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ex_done_i && st_done_i) |-> (ex_tag_i != st_tag_i)) else $error("ex/st tag clash");
    a_mem_st_tags: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (mem_done_i && st_done_i) |-> (mem_tag_i != st_tag_i)) else $error("mem/st tag clash");

    a_ex_live: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ex_done_i |-> (slot_state[ex_tag_i] != hist_pkg::EMPTY)) else $error("ex on empty slot");
    a_mem_live: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_done_i |-> (slot_state[mem_tag_i] != hist_pkg::EMPTY)) else $error("mem on empty slot");
    a_st_live: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        st_done_i |-> (slot_state[st_tag_i] != hist_pkg::EMPTY)) else $error("st on empty slot");

    // recovery ends only by draining the queue
    a_rec_end: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(recovering_o) |-> $rose(empty_o)) else $error("recovery ended early");

endmodule

bind history_file precise_state_props i_props (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ex_done_i    (ex_done_i),
    .ex_tag_i     (ex_tag_i),
    .mem_done_i   (mem_done_i),
    .mem_tag_i    (mem_tag_i),
    .st_done_i    (st_done_i),
    .st_tag_i     (st_tag_i),
    .empty_o      (empty_o),
    .recovering_o (recovering_o),
    .slot_state   (slot_state)
);

/* hdl/precise_state_top.sv */
`timescale 1ns/10ps

module precise_state_top (
    input  logic               clk_i,
    input  logic               arst_n_i,

    input  logic               issue_i,
    input  logic               issue_store_i,
    input  hist_pkg::reg_idx_t issue_reg_i,
    output hist_pkg::hf_ptr_t  issue_tag_o,

    input  logic               ex_done_i,
    input  hist_pkg::hf_ptr_t  ex_tag_i,
    input  hist_pkg::reg_idx_t ex_reg_i,
    input  hist_pkg::word_t    ex_value_i,

    input  logic               mem_done_i,
    input  hist_pkg::hf_ptr_t  mem_tag_i,
    input  hist_pkg::reg_idx_t mem_reg_i,
    input  hist_pkg::word_t    mem_value_i,

    input  logic               st_done_i,
    input  hist_pkg::hf_ptr_t  st_tag_i,

    input  logic               exc_i,
    input  hist_pkg::hf_ptr_t  exc_tag_i,

    input  hist_pkg::reg_idx_t rd_reg_i,
    output hist_pkg::word_t    rd_value_o,

    output logic               full_o,
    output logic               empty_o,
    output logic               store_permission_o,
    output logic               recovering_o
);

    rollback_if i_rollback_if ();

    // the issuing destination feeds the old-value read and the slot record
    assign i_rollback_if.alloc_reg = issue_reg_i;

    history_file i_history_file (
        .clk_i              (clk_i),
        .arst_n_i           (arst_n_i),
        .issue_i            (issue_i),
        .issue_store_i      (issue_store_i),
        .issue_tag_o        (issue_tag_o),
        .ex_done_i          (ex_done_i),
        .ex_tag_i           (ex_tag_i),
        .mem_done_i         (mem_done_i),
        .mem_tag_i          (mem_tag_i),
        .st_done_i          (st_done_i),
        .st_tag_i           (st_tag_i),
        .exc_i              (exc_i),
        .exc_tag_i          (exc_tag_i),
        .full_o             (full_o),
        .empty_o            (empty_o),
        .store_permission_o (store_permission_o),
        .recovering_o       (recovering_o),
        .rb                 (i_rollback_if.hist)
    );

    // ALU results go to wr0 and memory results to wr1
    register_file i_register_file (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .wr0_en_i    (ex_done_i),
        .wr0_reg_i   (ex_reg_i),
        .wr0_value_i (ex_value_i),
        .wr1_en_i    (mem_done_i),
        .wr1_reg_i   (mem_reg_i),
        .wr1_value_i (mem_value_i),
        .rd_reg_i    (rd_reg_i),
        .rd_value_o  (rd_value_o),
        .rb          (i_rollback_if.regs)
    );

endmodule

/* hdl/history_file.sv */
`timescale 1ns/10ps

`include "hist_defines.svh"

module history_file (
    input  logic               clk_i,
    input  logic               arst_n_i,

    input  logic               issue_i,
    input  logic               issue_store_i,
    output hist_pkg::hf_ptr_t  issue_tag_o,

    input  logic               ex_done_i,
    input  hist_pkg::hf_ptr_t  ex_tag_i,
    input  logic               mem_done_i,
    input  hist_pkg::hf_ptr_t  mem_tag_i,
    input  logic               st_done_i,
    input  hist_pkg::hf_ptr_t  st_tag_i,

    input  logic               exc_i,
    input  hist_pkg::hf_ptr_t  exc_tag_i,

    output logic               full_o,
    output logic               empty_o,
    output logic               store_permission_o,
    output logic               recovering_o,

    rollback_if.hist           rb
);

    // per-slot status, destination register and saved old value
    hist_pkg::slot_state_e slot_state [`HF_DEPTH];
    hist_pkg::slot_state_e state_nxt  [`HF_DEPTH];
    hist_pkg::reg_idx_t    slot_reg   [`HF_DEPTH];
    hist_pkg::word_t       slot_value [`HF_DEPTH];

    hist_pkg::hf_ptr_t  head;
    hist_pkg::hf_ptr_t  tail;
    hist_pkg::hf_ptr_t  head_nxt;
    hist_pkg::hf_ptr_t  tail_nxt;
    hist_pkg::hf_ptr_t  tail_prev;
    hist_pkg::hf_mode_e mode;
    hist_pkg::hf_mode_e mode_nxt;

    logic issue_ok;

    assign tail_prev = tail - 1'b1;

    assign empty_o            = (head == tail);
    assign full_o             = ((tail + 1'b1) == head);
    assign store_permission_o = (slot_state[head] == hist_pkg::EXECUTING_STORE);
    assign recovering_o       = (mode == hist_pkg::RECOVERING);
    assign issue_tag_o        = tail;

    assign issue_ok = issue_i && !full_o && (mode == hist_pkg::NORMAL);

    // the youngest valid slot drives the restore port
    assign rb.restore_en    = (mode == hist_pkg::RECOVERING);
    assign rb.restore_reg   = slot_reg[tail_prev];
    assign rb.restore_value = slot_value[tail_prev];

    always_comb begin : next_state
        hist_pkg::hf_ptr_t walk;
        logic              walking;

        state_nxt = slot_state;
        head_nxt  = head;
        tail_nxt  = tail;
        mode_nxt  = mode;
        walk      = head;
        walking   = 1'b1;

        case (mode)
            hist_pkg::NORMAL: begin
                if (issue_ok) begin
                    state_nxt[tail] = issue_store_i ? hist_pkg::EXECUTING_STORE
                                                    : hist_pkg::EXECUTING;
                    tail_nxt = tail + 1'b1;
                end

                // marks only land on slots that are in flight
                if (ex_done_i && slot_state[ex_tag_i] != hist_pkg::EMPTY) begin
                    state_nxt[ex_tag_i] = hist_pkg::DONE;
                end
                if (mem_done_i && slot_state[mem_tag_i] != hist_pkg::EMPTY) begin
                    state_nxt[mem_tag_i] = hist_pkg::DONE;
                end
                if (st_done_i && slot_state[st_tag_i] != hist_pkg::EMPTY) begin
                    state_nxt[st_tag_i] = hist_pkg::DONE;
                end
                // a faulting instruction never counts as done
                if (exc_i && slot_state[exc_tag_i] != hist_pkg::EMPTY) begin
                    state_nxt[exc_tag_i] = hist_pkg::FAULTED;
                end

                // retire every contiguous finished slot from the head in this edge
                for (int i = 0; i < `HF_DEPTH; i++) begin
                    if (walking && walk != tail_nxt && state_nxt[walk] == hist_pkg::DONE) begin
                        state_nxt[walk] = hist_pkg::EMPTY;
                        walk = walk + 1'b1;
                    end else begin
                        walking = 1'b0;
                    end
                end
                head_nxt = walk;

                if (slot_state[head] == hist_pkg::FAULTED) begin
                    mode_nxt = hist_pkg::RECOVERING;
                end
            end

            hist_pkg::RECOVERING: begin
                // pop the youngest slot, its old value goes out on the restore port
                tail_nxt = tail_prev;
                state_nxt[tail_prev] = hist_pkg::EMPTY;
                if (tail_prev == head) begin
                    mode_nxt = hist_pkg::NORMAL;
                end
            end

            default: begin
                mode_nxt = hist_pkg::NORMAL;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            head <= '0;
            tail <= '0;
            mode <= hist_pkg::NORMAL;
            for (int i = 0; i < `HF_DEPTH; i++) begin
                slot_state[i] <= hist_pkg::EMPTY;
            end
        end else begin
            head       <= head_nxt;
            tail       <= tail_nxt;
            mode       <= mode_nxt;
            slot_state <= state_nxt;
        end
    end

    // the old value is sampled from the register file as the slot is taken
    always_ff @(posedge clk_i) begin
        if (issue_ok) begin
            slot_reg[tail]   <= rb.alloc_reg;
            slot_value[tail] <= rb.old_value;
        end
    end

endmodule

/* hdl/register_file.sv */
`timescale 1ns/10ps

`include "hist_defines.svh"

module register_file (
    input  logic               clk_i,
    input  logic               arst_n_i,

    input  logic               wr0_en_i,
    input  hist_pkg::reg_idx_t wr0_reg_i,
    input  hist_pkg::word_t    wr0_value_i,

    input  logic               wr1_en_i,
    input  hist_pkg::reg_idx_t wr1_reg_i,
    input  hist_pkg::word_t    wr1_value_i,

    input  hist_pkg::reg_idx_t rd_reg_i,
    output hist_pkg::word_t    rd_value_o,

    rollback_if.regs           rb
);

    localparam int NUM_REGS = 2 ** `REG_IDX_W;

    // register 0 has no storage and always reads as zero
    hist_pkg::word_t regs [1:NUM_REGS-1];

    function automatic hist_pkg::word_t read_reg(input hist_pkg::reg_idx_t idx);
        hist_pkg::word_t value;

        value = '0;
        if (idx != '0) begin
            value = regs[idx];
        end
        return value;
    endfunction

    assign rd_value_o   = read_reg(rd_reg_i);
    assign rb.old_value = read_reg(rb.alloc_reg);

    // every architectural register reads zero after reset
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int r = 1; r < NUM_REGS; r++) begin
                // a restore undoes the write, so it wins over a writeback
                if (rb.restore_en && rb.restore_reg == hist_pkg::reg_idx_t'(r)) begin
                    regs[r] <= rb.restore_value;
                end else if (wr1_en_i && wr1_reg_i == hist_pkg::reg_idx_t'(r)) begin
                    regs[r] <= wr1_value_i;
                end else if (wr0_en_i && wr0_reg_i == hist_pkg::reg_idx_t'(r)) begin
                    regs[r] <= wr0_value_i;
                end
            end
        end
    end

endmodule

/* hdl/rollback_if.sv */
`timescale 1ns/10ps

interface rollback_if;

    // allocation group, the issuing destination and its value before the write
    hist_pkg::reg_idx_t alloc_reg;
    hist_pkg::word_t    old_value;

    // restore group, one saved value per cycle while recovering
    logic               restore_en;
    hist_pkg::reg_idx_t restore_reg;
    hist_pkg::word_t    restore_value;

    modport regs (
        input  alloc_reg,
        output old_value,
        input  restore_en,
        input  restore_reg,
        input  restore_value
    );

    modport hist (
        input  alloc_reg,
        input  old_value,
        output restore_en,
        output restore_reg,
        output restore_value
    );

endinterface

/* hdl/hist_pkg.sv */
package hist_pkg;

`include "hist_defines.svh"

    // one data word as held in the register file and in a history slot
    typedef logic [`WORD_W-1:0] word_t;

    // architectural register index
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // slot identifier, also the tag an instruction carries down the pipelines
    typedef logic [`HF_PTR_W-1:0] hf_ptr_t;

    // lifetime of one history slot
    // EXECUTING_STORE marks a store that waits for permission at the head
    typedef enum logic [2:0] {
        EMPTY,
        EXECUTING,
        EXECUTING_STORE,
        DONE,
        FAULTED
    } slot_state_e;

    // queue mode, RECOVERING while old values are being written back
    typedef enum logic {
        NORMAL,
        RECOVERING
    } hf_mode_e;

endpackage

/* hdl/hist_defines.svh */
`ifndef HIST_DEFINES_SVH
`define HIST_DEFINES_SVH

// number of slots in the history file
// one slot always stays unused so that full and empty can be told apart
`define HF_DEPTH 8

// slot index width, log2 of HF_DEPTH
// the pointers wrap naturally because the depth is a power of two
`define HF_PTR_W 3

// architectural register index width, giving 32 registers
`define REG_IDX_W 5

// data word width
`define WORD_W 32

`endif
